// ==== hw/amba_axi_pkg.sv ====
// AXI4 channel structs, response codes and idle bus constants
package amba_axi_pkg;

    localparam int AXI_ADDR_BITS = 32;
    localparam int AXI_DATA_BITS = 32;
    localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;
    localparam int AXI_ID_BITS = 4;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_DECERR = 2'b11;

    // Address beat, same layout on AR and AW
    typedef struct packed {
        logic [AXI_ADDR_BITS-1:0] addr;
        logic [7:0] len;                    // Beats minus one
        logic [2:0] size;
        logic [1:0] burst;
        logic [AXI_ID_BITS-1:0] id;
    } axi4_addr_type;

    typedef struct packed {
        logic ar_valid;
        axi4_addr_type ar_bits;
        logic aw_valid;
        axi4_addr_type aw_bits;
        logic w_valid;
        logic [AXI_DATA_BITS-1:0] w_data;
        logic [AXI_STRB_BITS-1:0] w_strb;
        logic w_last;
        logic r_ready;
        logic b_ready;
    } axi4_master_out_type;

    typedef struct packed {
        logic ar_ready;
        logic aw_ready;
        logic w_ready;
        logic r_valid;
        logic [AXI_DATA_BITS-1:0] r_data;
        logic [1:0] r_resp;
        logic r_last;
        logic [AXI_ID_BITS-1:0] r_id;
        logic b_valid;
        logic [1:0] b_resp;
        logic [AXI_ID_BITS-1:0] b_id;
    } axi4_master_in_type;

    // Slave side sees the master channels mirrored
    typedef axi4_master_out_type axi4_slave_in_type;
    typedef axi4_master_in_type axi4_slave_out_type;

    // Idle values, no valid or ready asserted
    localparam axi4_master_out_type axi4_master_out_none = '0;
    localparam axi4_master_in_type axi4_master_in_none = '0;
    localparam axi4_slave_in_type axi4_slave_in_none = '0;
    localparam axi4_slave_out_type axi4_slave_out_none = '0;

endpackage

// ==== hw/bus0_map_pkg.sv ====
// Bus0 sizes, master and slave counts, routing types and the address map
package bus0_map_pkg;

    localparam int BUS0_XMST_TOTAL = 2;
    localparam int BUS0_XSLV_TOTAL = 2;
    localparam int BUS0_PAGE_BITS = 12;     // 4 KB decode granularity

    typedef logic [1:0] bus0_sidx_type;
    typedef logic [1:0] bus0_midx_type;

    localparam bus0_sidx_type BUS0_SIDX_DEF = bus0_sidx_type'(BUS0_XSLV_TOTAL);
    localparam bus0_midx_type BUS0_MIDX_NONE = bus0_midx_type'(BUS0_XMST_TOTAL);

    // Master and slave pair of one routed channel
    typedef struct packed {
        bus0_midx_type midx;
        bus0_sidx_type sidx;
    } bus0_route_type;

    localparam bus0_route_type BUS0_ROUTE_NONE = '{midx: BUS0_MIDX_NONE, sidx: BUS0_SIDX_DEF};

    typedef struct packed {
        logic [31:0] addr_start;
        logic [31:0] addr_end;              // Exclusive
    } bus0_map_entry_type;

    localparam bus0_map_entry_type [BUS0_XSLV_TOTAL-1:0] BUS0_MAP = '{
        0: '{addr_start: 32'h0000_0000, addr_end: 32'h0000_1000},
        1: '{addr_start: 32'h0000_1000, addr_end: 32'h0000_2000}
    };

    typedef amba_axi_pkg::axi4_master_out_type [BUS0_XMST_TOTAL-1:0] bus0_xmst_out_vector;
    typedef amba_axi_pkg::axi4_master_in_type [BUS0_XMST_TOTAL-1:0] bus0_xmst_in_vector;
    // Slave vectors carry one extra slot for the default slave
    typedef amba_axi_pkg::axi4_slave_out_type [BUS0_XSLV_TOTAL:0] bus0_xslv_out_vector;
    typedef amba_axi_pkg::axi4_slave_in_type [BUS0_XSLV_TOTAL:0] bus0_xslv_in_vector;

endpackage

// ==== hw/bus0_addr_decode.sv ====
// Bus0 address decoder for AR and AW with default slave fallback
`timescale 1ns/10ps

module bus0_addr_decode (
    input  logic [31:0] i_ar_addr,
    input  logic [31:0] i_aw_addr,
    output bus0_map_pkg::bus0_sidx_type o_ar_sidx,
    output bus0_map_pkg::bus0_sidx_type o_aw_sidx
);
    import bus0_map_pkg::*;

    // Page compare against every map entry, later entries win
    function automatic bus0_sidx_type lookup(input logic [31:0] addr);
        bus0_sidx_type sidx;
        logic [31-BUS0_PAGE_BITS:0] page;
        sidx = BUS0_SIDX_DEF;
        page = addr[31:BUS0_PAGE_BITS];
        for (int i = 0; i < BUS0_XSLV_TOTAL; i++) begin
            if ((page >= BUS0_MAP[i].addr_start[31:BUS0_PAGE_BITS])
                    && (page < BUS0_MAP[i].addr_end[31:BUS0_PAGE_BITS])) begin
                sidx = bus0_sidx_type'(i);
            end
        end
        return sidx;
    endfunction

    assign o_ar_sidx = lookup(i_ar_addr);
    assign o_aw_sidx = lookup(i_aw_addr);

endmodule

// ==== hw/bus0_xbar_route.sv ====
// Bus0 crossbar master selection, route registers and channel muxing
`timescale 1ns/10ps

module bus0_xbar_route (
    input  logic i_clk,
    input  logic i_nrst,
    input  bus0_map_pkg::bus0_xmst_out_vector i_xmsto,
    output bus0_map_pkg::bus0_xmst_in_vector  o_xmsti,
    input  bus0_map_pkg::bus0_xslv_out_vector i_xslvo,
    output bus0_map_pkg::bus0_xslv_in_vector  o_xslvi,
    output logic [31:0] o_ar_addr,
    output logic [31:0] o_aw_addr,
    input  bus0_map_pkg::bus0_sidx_type i_ar_sidx,
    input  bus0_map_pkg::bus0_sidx_type i_aw_sidx
);
    import amba_axi_pkg::*;
    import bus0_map_pkg::*;

    axi4_master_out_type msto [BUS0_XMST_TOTAL+1];  // Top slot is the idle master
    axi4_master_in_type msti [BUS0_XMST_TOTAL+1];
    bus0_midx_type ar_midx;
    bus0_midx_type aw_midx;
    bus0_route_type rd_q, rd_d;                     // Read data route
    bus0_route_type wr_q, wr_d;                     // Write data route
    bus0_route_type b_q, b_d;                       // Pending response route
    logic ar_fire, r_fire, r_busy;
    logic aw_fire, w_fire, w_busy;
    logic b_fire, b_busy;
    logic [BUS0_XMST_TOTAL-1:0] rd_open;            // Reads open as seen on the master ports

    always_comb begin
        ar_midx = BUS0_MIDX_NONE;
        aw_midx = BUS0_MIDX_NONE;
        for (int i = 0; i < BUS0_XMST_TOTAL; i++) begin
            msto[i] = i_xmsto[i];
            if (i_xmsto[i].ar_valid) begin
                ar_midx = bus0_midx_type'(i);       // Highest index wins
            end
            if (i_xmsto[i].aw_valid) begin
                aw_midx = bus0_midx_type'(i);
            end
        end
        msto[BUS0_XMST_TOTAL] = axi4_master_out_none;
    end

    assign o_ar_addr = msto[ar_midx].ar_bits.addr;
    assign o_aw_addr = msto[aw_midx].aw_bits.addr;

    always_comb begin
        // Final beats close a route
        r_fire = msto[rd_q.midx].r_ready & i_xslvo[rd_q.sidx].r_valid
                 & i_xslvo[rd_q.sidx].r_last;
        r_busy = (rd_q.midx != BUS0_MIDX_NONE) & ~r_fire;
        b_fire = msto[b_q.midx].b_ready & i_xslvo[b_q.sidx].b_valid;
        b_busy = (b_q.midx != BUS0_MIDX_NONE) & ~b_fire;
        w_fire = msto[wr_q.midx].w_valid & msto[wr_q.midx].w_last
                 & i_xslvo[wr_q.sidx].w_ready & ~b_busy;
        w_busy = ((wr_q.midx != BUS0_MIDX_NONE) & ~w_fire) | b_busy;
        ar_fire = msto[ar_midx].ar_valid & i_xslvo[i_ar_sidx].ar_ready & ~r_busy;
        aw_fire = msto[aw_midx].aw_valid & i_xslvo[i_aw_sidx].aw_ready & ~w_busy;

        rd_d = rd_q;
        if (ar_fire) begin
            rd_d = '{midx: ar_midx, sidx: i_ar_sidx};
        end else if (r_fire) begin
            rd_d = BUS0_ROUTE_NONE;
        end
        wr_d = wr_q;
        if (aw_fire) begin
            wr_d = '{midx: aw_midx, sidx: i_aw_sidx};
        end else if (w_fire) begin
            wr_d = BUS0_ROUTE_NONE;
        end
        b_d = b_q;
        if (w_fire) begin
            b_d = wr_q;                             // Write moves on to its response
        end else if (b_fire) begin
            b_d = BUS0_ROUTE_NONE;
        end
    end

    always_comb begin
        for (int i = 0; i <= BUS0_XMST_TOTAL; i++) begin
            msti[i] = axi4_master_in_none;
        end
        for (int i = 0; i <= BUS0_XSLV_TOTAL; i++) begin
            o_xslvi[i] = axi4_slave_in_none;
        end

        msti[ar_midx].ar_ready = i_xslvo[i_ar_sidx].ar_ready & ~r_busy;
        o_xslvi[i_ar_sidx].ar_valid = msto[ar_midx].ar_valid & ~r_busy;
        o_xslvi[i_ar_sidx].ar_bits = msto[ar_midx].ar_bits;

        msti[rd_q.midx].r_valid = i_xslvo[rd_q.sidx].r_valid;
        msti[rd_q.midx].r_data = i_xslvo[rd_q.sidx].r_data;
        msti[rd_q.midx].r_resp = i_xslvo[rd_q.sidx].r_resp;
        msti[rd_q.midx].r_last = i_xslvo[rd_q.sidx].r_last;
        msti[rd_q.midx].r_id = i_xslvo[rd_q.sidx].r_id;
        o_xslvi[rd_q.sidx].r_ready = msto[rd_q.midx].r_ready;

        msti[aw_midx].aw_ready = i_xslvo[i_aw_sidx].aw_ready & ~w_busy;
        o_xslvi[i_aw_sidx].aw_valid = msto[aw_midx].aw_valid & ~w_busy;
        o_xslvi[i_aw_sidx].aw_bits = msto[aw_midx].aw_bits;

        // W waits for an older B to drain
        msti[wr_q.midx].w_ready = i_xslvo[wr_q.sidx].w_ready & ~b_busy;
        o_xslvi[wr_q.sidx].w_valid = msto[wr_q.midx].w_valid & ~b_busy;
        o_xslvi[wr_q.sidx].w_data = msto[wr_q.midx].w_data;
        o_xslvi[wr_q.sidx].w_strb = msto[wr_q.midx].w_strb;
        o_xslvi[wr_q.sidx].w_last = msto[wr_q.midx].w_last;

        msti[b_q.midx].b_valid = i_xslvo[b_q.sidx].b_valid;
        msti[b_q.midx].b_resp = i_xslvo[b_q.sidx].b_resp;
        msti[b_q.midx].b_id = i_xslvo[b_q.sidx].b_id;
        o_xslvi[b_q.sidx].b_ready = msto[b_q.midx].b_ready;

        for (int i = 0; i < BUS0_XMST_TOTAL; i++) begin
            o_xmsti[i] = msti[i];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_q <= BUS0_ROUTE_NONE;
            wr_q <= BUS0_ROUTE_NONE;
            b_q <= BUS0_ROUTE_NONE;
        end else begin
            rd_q <= rd_d;
            wr_q <= wr_d;
            b_q <= b_d;
        end
    end

    // Opened by an AR handshake, closed by the R handshake with r_last
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_open <= '0;
        end else begin
            for (int i = 0; i < BUS0_XMST_TOTAL; i++) begin
                if (i_xmsto[i].ar_valid && o_xmsti[i].ar_ready) begin
                    rd_open[i] <= 1'b1;
                end else if (o_xmsti[i].r_valid && i_xmsto[i].r_ready
                             && o_xmsti[i].r_last) begin
                    rd_open[i] <= 1'b0;
                end
            end
        end
    end

    for (genvar gi = 0; gi < BUS0_XMST_TOTAL; gi++) begin : g_rd_check
        a_rd_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
            rd_open[gi] |-> (rd_q.midx == gi));
        a_r_owner: assert property (@(posedge i_clk) disable iff (!i_nrst)
            o_xmsti[gi].r_valid |-> rd_open[gi]);
    end

endmodule

// ==== hw/bus0_def_slave.sv ====
// Default AXI4 slave answering unmapped accesses with DECERR
`timescale 1ns/10ps

module bus0_def_slave (
    input  logic i_clk,
    input  logic i_nrst,
    input  amba_axi_pkg::axi4_slave_in_type  i_xslvi,
    output amba_axi_pkg::axi4_slave_out_type o_xslvo
);
    import amba_axi_pkg::*;

    logic rd_active;
    logic [7:0] rd_cnt;                     // Beats left after the current one
    logic [7:0] rd_len;                     // Requested beats minus one
    logic [7:0] rd_beat;                    // Beats already taken by the master
    logic [AXI_ID_BITS-1:0] rd_id;
    logic [AXI_ID_BITS-1:0] wr_id;
    logic b_valid;
    logic r_fire;

    assign r_fire = rd_active & i_xslvi.r_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_active <= 1'b0;
            rd_cnt <= '0;
            rd_len <= '0;
            rd_beat <= '0;
            rd_id <= '0;
            wr_id <= '0;
            b_valid <= 1'b0;
        end else begin
            if (i_xslvi.ar_valid) begin     // ar_ready is tied high
                rd_active <= 1'b1;
                rd_cnt <= i_xslvi.ar_bits.len;
                rd_len <= i_xslvi.ar_bits.len;
                rd_beat <= '0;
                rd_id <= i_xslvi.ar_bits.id;
            end else if (r_fire) begin
                rd_active <= (rd_cnt != '0);
                rd_cnt <= rd_cnt - 8'd1;
                rd_beat <= rd_beat + 8'd1;
            end
            if (i_xslvi.aw_valid) begin
                wr_id <= i_xslvi.aw_bits.id;
            end
            if (i_xslvi.w_valid && i_xslvi.w_last) begin
                b_valid <= 1'b1;
            end else if (i_xslvi.b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        o_xslvo = axi4_slave_out_none;
        o_xslvo.ar_ready = 1'b1;
        o_xslvo.aw_ready = 1'b1;
        o_xslvo.w_ready = 1'b1;             // Write data is dropped
        o_xslvo.r_valid = rd_active;
        o_xslvo.r_data = '1;
        o_xslvo.r_resp = AXI_RESP_DECERR;
        o_xslvo.r_last = rd_active && (rd_cnt == '0);
        o_xslvo.r_id = rd_id;
        o_xslvo.b_valid = b_valid;
        o_xslvo.b_resp = AXI_RESP_DECERR;
        o_xslvo.b_id = wr_id;
    end

    // Last flag only on the beat that completes the requested length
    a_last_final: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_xslvo.r_last |-> (rd_beat == rd_len));

endmodule

// ==== hw/axi_sram_slave.sv ====
// 4 KB AXI4 RAM slave with INCR bursts and byte strobes
`timescale 1ns/10ps

module axi_sram_slave (
    input  logic i_clk,
    input  logic i_nrst,
    input  amba_axi_pkg::axi4_slave_in_type  i_xslvi,
    output amba_axi_pkg::axi4_slave_out_type o_xslvo
);
    import amba_axi_pkg::*;

    logic [AXI_DATA_BITS-1:0] mem [1024];
    logic [AXI_DATA_BITS-1:0] rd_data;
    logic rd_active;
    logic [9:0] rd_word;                    // Word of the beat on the bus
    logic [7:0] rd_cnt;
    logic [AXI_ID_BITS-1:0] rd_id;
    logic wr_active;
    logic [9:0] wr_word;
    logic [AXI_ID_BITS-1:0] wr_id;
    logic b_valid;
    logic ar_fire, r_fire, r_last;
    logic aw_fire, w_fire;

    assign ar_fire = i_xslvi.ar_valid & ~rd_active;
    assign r_fire = rd_active & i_xslvi.r_ready;
    assign r_last = (rd_cnt == '0);
    assign aw_fire = i_xslvi.aw_valid & ~wr_active & ~b_valid;
    assign w_fire = i_xslvi.w_valid & wr_active;

    always_ff @(posedge i_clk) begin
        if (ar_fire) begin
            rd_data <= mem[i_xslvi.ar_bits.addr[11:2]];
        end else if (r_fire && !r_last) begin
            rd_data <= mem[rd_word + 10'd1];    // Prefetch next beat
        end
        if (w_fire) begin
            for (int b = 0; b < AXI_STRB_BITS; b++) begin
                if (i_xslvi.w_strb[b]) begin
                    mem[wr_word][8*b +: 8] <= i_xslvi.w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_active <= 1'b0;
            rd_word <= '0;
            rd_cnt <= '0;
            rd_id <= '0;
            wr_active <= 1'b0;
            wr_word <= '0;
            wr_id <= '0;
            b_valid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_active <= 1'b1;
                rd_word <= i_xslvi.ar_bits.addr[11:2];
                rd_cnt <= i_xslvi.ar_bits.len;
                rd_id <= i_xslvi.ar_bits.id;
            end else if (r_fire) begin
                rd_active <= !r_last;
                rd_word <= rd_word + 10'd1;
                rd_cnt <= rd_cnt - 8'd1;
            end
            if (aw_fire) begin
                wr_active <= 1'b1;
                wr_word <= i_xslvi.aw_bits.addr[11:2];
                wr_id <= i_xslvi.aw_bits.id;
            end else if (w_fire) begin
                wr_word <= wr_word + 10'd1;
                wr_active <= !i_xslvi.w_last;
                b_valid <= i_xslvi.w_last;      // B goes out the next cycle
            end
            if (b_valid && i_xslvi.b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        o_xslvo = axi4_slave_out_none;
        o_xslvo.ar_ready = ~rd_active;
        o_xslvo.aw_ready = ~wr_active & ~b_valid;
        o_xslvo.w_ready = wr_active;
        o_xslvo.r_valid = rd_active;
        o_xslvo.r_data = rd_data;
        o_xslvo.r_resp = AXI_RESP_OKAY;
        o_xslvo.r_last = rd_active & r_last;
        o_xslvo.r_id = rd_id;
        o_xslvo.b_valid = b_valid;
        o_xslvo.b_resp = AXI_RESP_OKAY;
        o_xslvo.b_id = wr_id;
    end

    // Word address only climbs inside a burst, so it never wraps past 4 KB
    a_rd_in_page: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (r_fire && !r_last) |=> (rd_word > $past(rd_word)));
    a_wr_in_page: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (w_fire && !i_xslvi.w_last) |=> (wr_word > $past(wr_word)));

endmodule

// ==== hw/bus0_subsys_top.sv ====
// Bus0 subsystem top with crossbar, decoder, default slave and two RAM slaves
`timescale 1ns/10ps

module bus0_subsys_top (
    input  logic i_clk,
    input  logic i_nrst,
    input  bus0_map_pkg::bus0_xmst_out_vector i_xmsto,
    output bus0_map_pkg::bus0_xmst_in_vector  o_xmsti
);
    import bus0_map_pkg::*;

    bus0_xslv_in_vector xslvi;
    bus0_xslv_out_vector xslvo;
    logic [31:0] ar_addr;
    logic [31:0] aw_addr;
    bus0_sidx_type ar_sidx;
    bus0_sidx_type aw_sidx;

    bus0_xbar_route xbar_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xmsto(i_xmsto),
        .o_xmsti(o_xmsti),
        .i_xslvo(xslvo),
        .o_xslvi(xslvi),
        .o_ar_addr(ar_addr),
        .o_aw_addr(aw_addr),
        .i_ar_sidx(ar_sidx),
        .i_aw_sidx(aw_sidx)
    );

    bus0_addr_decode decode_i (
        .i_ar_addr(ar_addr),
        .i_aw_addr(aw_addr),
        .o_ar_sidx(ar_sidx),
        .o_aw_sidx(aw_sidx)
    );

    // Extra slave slot answers unmapped addresses
    bus0_def_slave def_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(xslvi[BUS0_XSLV_TOTAL]),
        .o_xslvo(xslvo[BUS0_XSLV_TOTAL])
    );

    axi_sram_slave ram0_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(xslvi[0]),
        .o_xslvo(xslvo[0])
    );

    axi_sram_slave ram1_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(xslvi[1]),
        .o_xslvo(xslvo[1])
    );

endmodule

// ==== dv/tb_bus0_subsys.sv ====
// Testbench for the bus0 subsystem with data-file transactions, memory model and checks
`timescale 1ns/10ps

module tb_bus0_subsys;
    import amba_axi_pkg::*;
    import bus0_map_pkg::*;

    logic clk;
    logic nrst;
    bus0_xmst_out_vector xmsto;
    bus0_xmst_in_vector xmsti;
    logic [31:0] model [2048];              // Expected contents of both RAMs
    logic [31:0] wq [2][$];                 // Write data per master
    logic [31:0] lfsr;
    int errors = 0;
    int cycles = 0;
    int limit = 0;
    time aw_t [2];
    time done_t [2];

    bus0_subsys_top dut_i (.i_clk(clk), .i_nrst(nrst), .i_xmsto(xmsto), .o_xmsti(xmsti));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
        end
        $display("Timeout, the transactions did not complete within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic fill_words(input int m, input int beats);
        logic [31:0] w;
        for (int k = 0; k < beats; k++) begin
            for (int b = 0; b < 32; b++) begin
                w = {w[30:0], lfsr[0]};     // One step per bit
                lfsr = lfsr_step(lfsr);
            end
            wq[m].push_back(w);
        end
    endtask

    task automatic check_r(input axi4_master_in_type got, input axi4_master_in_type exp,
                           input string what);
        if (got.r_data !== exp.r_data || got.r_resp !== exp.r_resp
                || got.r_last !== exp.r_last || got.r_id !== exp.r_id) begin
            errors++;
            $display(
                "MISMATCH at %0t: %s data %h resp %0d last %0b id %0d, expected %h %0d %0b %0d",
                $time, what, got.r_data, got.r_resp, got.r_last, got.r_id,
                exp.r_data, exp.r_resp, exp.r_last, exp.r_id);
        end
    endtask

    task automatic check_b(input axi4_master_in_type got, input axi4_master_in_type exp,
                           input string what);
        if (got.b_resp !== exp.b_resp || got.b_id !== exp.b_id) begin
            errors++;
            $display("MISMATCH at %0t: %s resp %0d id %0d, expected %0d %0d",
                     $time, what, got.b_resp, got.b_id, exp.b_resp, exp.b_id);
        end
    endtask

    task automatic read_burst(input int m, input logic [31:0] addr, input int len,
                              input logic [1:0] resp, input logic use_mem,
                              input logic [31:0] lit, input logic [3:0] id);
        axi4_master_in_type exp;
        int k;
        k = 0;
        @(negedge clk);
        xmsto[m].ar_valid = 1'b1;
        xmsto[m].ar_bits = '{addr: addr, len: 8'(len), size: 3'd2, burst: 2'b01, id: id};
        xmsto[m].r_ready = 1'b1;
        do @(posedge clk); while (!xmsti[m].ar_ready);
        @(negedge clk);
        xmsto[m].ar_valid = 1'b0;
        while (k <= len) begin
            @(posedge clk);
            if (xmsti[m].r_valid) begin
                exp = axi4_master_in_none;
                exp.r_data = use_mem ? model[addr[12:2] + k] : lit;
                exp.r_resp = resp;
                exp.r_last = (k == len);
                exp.r_id = id;
                check_r(xmsti[m], exp, $sformatf("read master %0d beat %0d", m, k));
                k = xmsti[m].r_last ? len + 1 : k + 1;  // Early last ends the burst
            end
        end
        done_t[m] = $time;
        @(negedge clk);
        xmsto[m].r_ready = 1'b0;
    endtask

    task automatic write_burst(input int m, input logic [31:0] addr, input int len,
                               input logic [3:0] strb, input logic [1:0] resp,
                               input logic [3:0] id, input int hold);
        axi4_master_in_type exp;
        @(negedge clk);
        xmsto[m].aw_valid = 1'b1;
        xmsto[m].aw_bits = '{addr: addr, len: 8'(len), size: 3'd2, burst: 2'b01, id: id};
        do @(posedge clk); while (!xmsti[m].aw_ready);
        aw_t[m] = $time;
        for (int k = 0; k <= len; k++) begin
            @(negedge clk);
            xmsto[m].aw_valid = 1'b0;
            xmsto[m].w_valid = 1'b1;
            xmsto[m].w_data = wq[m][k];
            xmsto[m].w_strb = strb;
            xmsto[m].w_last = (k == len);
            do @(posedge clk); while (!xmsti[m].w_ready);
        end
        @(negedge clk);
        xmsto[m].w_valid = 1'b0;
        xmsto[m].w_last = 1'b0;
        repeat (hold) @(negedge clk);       // B parked by low b_ready
        xmsto[m].b_ready = 1'b1;
        do @(posedge clk); while (!xmsti[m].b_valid);
        done_t[m] = $time;
        exp = axi4_master_in_none;
        exp.b_resp = resp;
        exp.b_id = id;
        check_b(xmsti[m], exp, $sformatf("write master %0d", m));
        @(negedge clk);
        xmsto[m].b_ready = 1'b0;
        for (int k = 0; k <= len; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b] && addr < 32'h2000) begin
                    model[addr[12:2] + k][8*b +: 8] = wq[m][k][8*b +: 8];
                end
            end
        end
    endtask

    initial begin
        string line;
        string word;
        string lines[$];
        int fd;
        int n;
        int bad;
        int fails;
        int m;
        int len;
        byte op;
        logic [31:0] addr;
        logic [31:0] seed;
        logic [31:0] lit;
        logic [3:0] strb;
        logic [1:0] resp;
        logic use_mem;
        xmsto = '0;
        nrst = 1'b0;
        fails = 0;
        fd = $fopen("dv/bus0_input.txt", "r");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (lines.size() == 0) begin
            errors++;
            $display("No transactions could be read from dv/bus0_input.txt");
        end
        limit = 200 * lines.size() + 10;
        repeat (2) @(negedge clk);
        nrst = 1'b1;
        foreach (lines[i]) begin
            bad = errors;
            n = $sscanf(lines[i], "%c %d %h %d %h %h %h %s",
                        op, m, addr, len, seed, strb, resp, word);
            if (n != 8) begin
                errors++;
                $display("Line %0d of the data file has missing fields", i + 1);
            end
            use_mem = (word == "MEM");
            if (!use_mem && $sscanf(word, "%h", lit) != 1) begin
                errors++;
                $display("Line %0d of the data file has an unreadable expected word", i + 1);
            end
            lfsr = 32'd12007 ^ seed;
            wq[0].delete();
            wq[1].delete();
            if (op == "W" && m == 2) begin
                // Master 0 queues its AW while master 1 holds off its B
                fill_words(1, len + 1);
                fill_words(0, len + 1);
                fork
                    write_burst(1, addr, len, strb, resp, 4'(8 + i), 4);
                    begin
                        repeat (2) @(negedge clk);
                        write_burst(0, addr + 4 * (len + 1), len, strb, resp, 4'(i), 0);
                    end
                join
                if (aw_t[0] < done_t[1]) begin
                    errors++;
                    $display("Second AW was accepted at %0t before the held B at %0t",
                             aw_t[0], done_t[1]);
                end
            end else if (op == "R" && m == 2) begin
                fork
                    read_burst(1, addr, len, resp, use_mem, lit, 4'(8 + i));
                    read_burst(0, addr, len, resp, use_mem, lit, 4'(i));
                join
                if (done_t[1] >= done_t[0]) begin
                    errors++;
                    $display("Master 0 finished its read before master 1");
                end
            end else if (op == "R") begin
                read_burst(m, addr, len, resp, use_mem, lit, 4'(8 * m + i));
            end else begin
                fill_words(m, len + 1);
                write_burst(m, addr, len, strb, resp, 4'(8 * m + i), 0);
            end
            fails += (errors != bad);
            $display("test %0d %c master %0d addr %h len %0d: %s", i + 1, op, m, addr, len,
                     (errors == bad) ? "ok" : "failed");
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", lines.size(),
                 lines.size() - fails, fails, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/bus0_input.txt ====
# op master addr len seed strobe resp first_word (MEM means the memory model)
# master 2 runs both masters together and for W master 1 holds its B while master 0 writes
W 0 00000000 0 0011 F 0 MEM
R 0 00000000 0 0 F 0 MEM
W 1 00000010 3 0022 F 0 MEM
R 1 00000010 3 0 F 0 MEM
W 0 00001020 3 0033 F 0 MEM
W 1 00001020 3 0044 5 0 MEM
R 0 00001020 3 0 F 0 MEM
W 1 00001ff0 1 0055 F 0 MEM
R 1 00001ff0 1 0 F 0 MEM
R 0 00008000 0 0 F 3 FFFFFFFF
R 1 00008000 3 0 F 3 FFFFFFFF
W 0 00008000 1 0066 F 3 MEM
R 2 00000010 3 0 F 0 MEM
W 2 00000100 1 0077 F 0 MEM
R 0 00000100 1 0 F 0 MEM
R 1 00000108 1 0 F 0 MEM
W 2 00001100 0 0088 F 0 MEM
R 1 00001100 0 0 F 0 MEM
R 0 00001104 0 0 F 0 MEM
R 2 00008000 1 0 F 3 FFFFFFFF
W 1 00000ffc 0 0099 F 0 MEM
R 0 00000ffc 0 0 F 0 MEM

// ==== filelist.f ====
hw/amba_axi_pkg.sv
hw/bus0_map_pkg.sv
hw/bus0_addr_decode.sv
hw/bus0_xbar_route.sv
hw/bus0_def_slave.sv
hw/axi_sram_slave.sv
hw/bus0_subsys_top.sv
dv/tb_bus0_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_bus0_subsys -o sim_bus0 || exit 1

out="$(./obj_dir/sim_bus0)"
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
